//--- logic/aesPkg.sv
`default_nettype none

package aesPkg;

    localparam int blockBits = 128;
    localparam int roundBits = 4;
    localparam logic [roundBits-1:0] numRounds = 4'd10;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // One 128-bit state, seen as bytes or as columns.
    // Column c holds bytes 4c+3..4c, row 0 in the top byte.
    typedef union packed
    {
        byte_t [15:0] bytes;
        word_t [3:0]  cols;
    } aesState_u;

    // Key words w0 (index 0, most significant) to w3.
    typedef word_t [0:3] cipherKey_t;

    typedef struct packed
    {
        aesState_u  plaintext;
        cipherKey_t key;
    } aesReq_t;

    // Forward S-box, entry 0 in the top byte.
    localparam logic [2047:0] sBoxTable =
    {
        64'h637c_777b_f26b_6fc5, 64'h3001_672b_fed7_ab76,
        64'hca82_c97d_fa59_47f0, 64'hadd4_a2af_9ca4_72c0,
        64'hb7fd_9326_363f_f7cc, 64'h34a5_e5f1_71d8_3115,
        64'h04c7_23c3_1896_059a, 64'h0712_80e2_eb27_b275,
        64'h0983_2c1a_1b6e_5aa0, 64'h523b_d6b3_29e3_2f84,
        64'h53d1_00ed_20fc_b15b, 64'h6acb_be39_4a4c_58cf,
        64'hd0ef_aafb_434d_3385, 64'h45f9_027f_503c_9fa8,
        64'h51a3_408f_929d_38f5, 64'hbcb6_da21_10ff_f3d2,
        64'hcd0c_13ec_5f97_4417, 64'hc4a7_7e3d_645d_1973,
        64'h6081_4fdc_222a_9088, 64'h46ee_b814_de5e_0bdb,
        64'he032_3a0a_4906_245c, 64'hc2d3_ac62_9195_e479,
        64'he7c8_376d_8dd5_4ea9, 64'h6c56_f4ea_657a_ae08,
        64'hba78_252e_1ca6_b4c6, 64'he8dd_741f_4bbd_8b8a,
        64'h703e_b566_4803_f60e, 64'h6135_57b9_86c1_1d9e,
        64'he1f8_9811_69d9_8e94, 64'h9b1e_87e9_ce55_28df,
        64'h8ca1_890d_bfe6_4268, 64'h4199_2d0f_b054_bb16
    };

    function automatic byte_t sBox(byte_t b);
        return sBoxTable[(255 - int'(b)) * 8 +: 8];
    endfunction

    // Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1.
    function automatic byte_t xtime(byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7])
        begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

`default_nettype wire

//--- logic/aesKeySchedule.sv
`timescale 1ns/1ps
`default_nettype none

module aesKeySchedule
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               load,
    input  logic               step,
    input  aesPkg::cipherKey_t cipherKey,
    output aesPkg::cipherKey_t roundKey
);

    aesPkg::cipherKey_t keyReg;      // Previous round key.
    aesPkg::byte_t      rcon;
    aesPkg::word_t      rotWord;
    aesPkg::word_t      subWord;
    aesPkg::word_t      tempWord;
    aesPkg::cipherKey_t nextKey;

    assign rotWord  = {keyReg[3][23:0], keyReg[3][31:24]};
    assign tempWord = subWord ^ {rcon, 24'h000000};

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            subWord[8 * i +: 8] = aesPkg::sBox(rotWord[8 * i +: 8]);
        end
    end

    // Each word folds in the one just made.
    always_comb
    begin
        nextKey[0] = keyReg[0] ^ tempWord;
        for (int i = 1; i < 4; i++)
        begin
            nextKey[i] = keyReg[i] ^ nextKey[i - 1];
        end
    end

    assign roundKey = nextKey;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rcon <= 8'h01;
        end
        else if (load)
        begin
            rcon <= 8'h01;
        end
        else if (step)
        begin
            rcon <= aesPkg::xtime(rcon);   // 0x80 wraps to 0x1b.
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            keyReg <= cipherKey;
        end
        else if (step)
        begin
            keyReg <= nextKey;
        end
    end

endmodule

`default_nettype wire

//--- logic/aesRoundDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module aesRoundDatapath
(
    input  aesPkg::aesState_u state,
    input  logic              lastRound,
    output aesPkg::aesState_u roundOut
);

    aesPkg::aesState_u subState;
    aesPkg::aesState_u shiftState;
    aesPkg::aesState_u mixState;

    // One column times the fixed MixColumns matrix.
    function automatic aesPkg::word_t mixColumn(aesPkg::word_t col);
        aesPkg::byte_t a0;
        aesPkg::byte_t a1;
        aesPkg::byte_t a2;
        aesPkg::byte_t a3;
        aesPkg::byte_t d0;
        aesPkg::byte_t d1;
        aesPkg::byte_t d2;
        aesPkg::byte_t d3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        d0 = aesPkg::xtime(a0);
        d1 = aesPkg::xtime(a1);
        d2 = aesPkg::xtime(a2);
        d3 = aesPkg::xtime(a3);
        return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
                a0 ^ d1 ^ d2 ^ a2 ^ a3,
                a0 ^ a1 ^ d2 ^ d3 ^ a3,
                d0 ^ a0 ^ a1 ^ a2 ^ d3};
    endfunction

    always_comb
    begin
        for (int i = 0; i < aesPkg::blockBits / 8; i++)
        begin
            subState.bytes[i] = aesPkg::sBox(state.bytes[i]);
        end
    end

    // Row r rotates left by r.
    // Here c counts AES columns from the left, so column c sits at cols[3 - c].
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shiftState.bytes[15 - (4 * c + r)] =
                    subState.bytes[15 - (4 * ((c + r) % 4) + r)];
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixState.cols[c] = mixColumn(shiftState.cols[c]);
        end
    end

    assign roundOut = lastRound ? shiftState : mixState;   // Final round has no MixColumns.

endmodule

`default_nettype wire

//--- logic/aesRoundControl.sv
`timescale 1ns/1ps
`default_nettype none

module aesRoundControl
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               req,
    input  aesPkg::aesReq_t    reqData,
    input  aesPkg::aesState_u  roundOut,
    input  aesPkg::cipherKey_t roundKey,
    output logic               ack,
    output logic               load,
    output logic               step,
    output aesPkg::aesState_u  state,
    output logic               lastRound
);

    typedef enum logic [1:0]
    {
        statusIdle,
        statusBusy,
        statusDone
    } status_t;

    status_t                      status;
    logic [aesPkg::roundBits-1:0] roundCnt;

    assign load      = req && (status == statusIdle);
    assign step      = (status == statusBusy);
    assign lastRound = (roundCnt == aesPkg::numRounds);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            status   <= statusIdle;
            roundCnt <= '0;
            ack      <= 1'b0;
        end
        else
        begin
            case (status)
                statusIdle:
                begin
                    if (load)
                    begin
                        status   <= statusBusy;
                        roundCnt <= roundCnt + 1'b1;   // Sits at 0 while idle.
                    end
                end
                statusBusy:
                begin
                    if (lastRound)
                    begin
                        status   <= statusDone;
                        roundCnt <= '0;
                    end
                    else
                    begin
                        roundCnt <= roundCnt + 1'b1;
                    end
                end
                statusDone:
                begin
                    // Hold the result until the requester lets go.
                    if (!ack)
                    begin
                        ack <= 1'b1;
                    end
                    else if (!req)
                    begin
                        ack    <= 1'b0;
                        status <= statusIdle;
                    end
                end
                default:
                begin
                    status <= statusIdle;
                end
            endcase
        end
    end

    // AddRoundKey on the way into the register.
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            state <= reqData.plaintext ^ reqData.key;
        end
        else if (step)
        begin
            state <= roundOut ^ roundKey;
        end
    end

endmodule

`default_nettype wire

//--- logic/aesCore.sv
`timescale 1ns/1ps
`default_nettype none

module aesCore
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              req,
    input  aesPkg::aesReq_t   reqData,
    output logic              ack,
    output aesPkg::aesState_u dout
);

    logic               load;
    logic               step;
    logic               lastRound;
    aesPkg::cipherKey_t roundKey;
    aesPkg::aesState_u  roundOut;

    aesKeySchedule u_aesKeySchedule
    (
        .clk       (clk),
        .arstN     (arstN),
        .load      (load),
        .step      (step),
        .cipherKey (reqData.key),
        .roundKey  (roundKey)
    );

    // The state register drives both the round logic and the result port.
    aesRoundDatapath u_aesRoundDatapath
    (
        .state     (dout),
        .lastRound (lastRound),
        .roundOut  (roundOut)
    );

    aesRoundControl u_aesRoundControl
    (
        .clk       (clk),
        .arstN     (arstN),
        .req       (req),
        .reqData   (reqData),
        .roundOut  (roundOut),
        .roundKey  (roundKey),
        .ack       (ack),
        .load      (load),
        .step      (step),
        .state     (dout),
        .lastRound (lastRound)
    );

endmodule

`default_nettype wire

//--- dv/aesCoreAsserts.sv
`timescale 1ns/1ps
`default_nettype none

module aesCoreAsserts
(
    input logic              clk,
    input logic              arstN,
    input logic              req,
    input logic              ack,
    input aesPkg::aesState_u state
);

    // The core may only let go of ack once the requester has let go of req.
    ackHeldWhileReq: assert property (@(posedge clk) disable iff (!arstN)
        ack && req |=> ack)
        else $error("ack fell while req was still high");

    ackFollowsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose with no request pending");

    // Result is frozen for as long as it is offered.
    stateStableWhileAck: assert property (@(posedge clk) disable iff (!arstN)
        ack ##1 ack |-> $stable(state))
        else $error("state changed while ack was high");

endmodule

`default_nettype wire

//--- dv/aesChecker.sv
`timescale 1ns/1ps
`default_nettype none

module aesChecker
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              req,
    input  aesPkg::aesReq_t   reqData,
    input  logic              ack,
    input  aesPkg::aesState_u dout,
    input  logic [1:0]        testKind,
    output int                testsRun,
    output int                errorCount
);

    localparam logic [1:0]   kindKnown   = 2'd0;
    localparam logic [1:0]   kindSameKey = 2'd2;
    localparam int           ackLatency  = 11;
    localparam logic [127:0] knownCipher = 128'h69c4_e0d8_6a7b_0430_d8cd_b780_70b4_c55a;

    logic         reqPrev;
    logic         ackPrev;
    int           edgeCount;
    int           reqEdge;
    logic [1:0]   kind;
    logic [127:0] expected;
    logic [127:0] sameKeyResult;
    logic         haveSameKey;
    string        testName;

    function automatic string kindName(logic [1:0] k);
        case (k)
            kindKnown:   return "known";
            kindSameKey: return "sameKey";
            default:     return "random";
        endcase
    endfunction

    function automatic aesPkg::byte_t times3(aesPkg::byte_t b);
        return aesPkg::xtime(b) ^ b;
    endfunction

    // Straight FIPS-197 encryption with the whole key expanded up front.
    // Byte i of the block is s[i], column c is s[4c] to s[4c+3].
    function automatic logic [127:0] refEncrypt(logic [127:0] plaintext, logic [127:0] key);
        aesPkg::word_t w [0:43];
        aesPkg::byte_t s [0:15];
        aesPkg::byte_t t [0:15];
        aesPkg::word_t temp;
        aesPkg::byte_t rc;
        logic [127:0]  result;
        rc = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = key[127 - 32 * i -: 32];
        end
        for (int i = 4; i < 44; i++)
        begin
            temp = w[i - 1];
            if (i % 4 == 0)
            begin
                temp = {aesPkg::sBox(temp[23:16]), aesPkg::sBox(temp[15:8]),
                        aesPkg::sBox(temp[7:0]), aesPkg::sBox(temp[31:24])} ^ {rc, 24'h0};
                rc = aesPkg::xtime(rc);
            end
            w[i] = w[i - 4] ^ temp;
        end
        for (int i = 0; i < 16; i++)
        begin
            s[i] = plaintext[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
        end
        for (int round = 1; round <= 10; round++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    t[4 * c + r] = aesPkg::sBox(s[4 * ((c + r) % 4) + r]);   // Sub and shift.
                end
            end
            for (int c = 0; c < 4; c++)
            begin
                if (round < 10)
                begin
                    s[4 * c]     = aesPkg::xtime(t[4 * c]) ^ times3(t[4 * c + 1])
                                   ^ t[4 * c + 2] ^ t[4 * c + 3];
                    s[4 * c + 1] = t[4 * c] ^ aesPkg::xtime(t[4 * c + 1])
                                   ^ times3(t[4 * c + 2]) ^ t[4 * c + 3];
                    s[4 * c + 2] = t[4 * c] ^ t[4 * c + 1]
                                   ^ aesPkg::xtime(t[4 * c + 2]) ^ times3(t[4 * c + 3]);
                    s[4 * c + 3] = times3(t[4 * c]) ^ t[4 * c + 1]
                                   ^ t[4 * c + 2] ^ aesPkg::xtime(t[4 * c + 3]);
                end
                else
                begin
                    for (int r = 0; r < 4; r++)
                    begin
                        s[4 * c + r] = t[4 * c + r];
                    end
                end
                for (int r = 0; r < 4; r++)
                begin
                    s[4 * c + r] = s[4 * c + r] ^ w[4 * round + c][31 - 8 * r -: 8];
                end
            end
        end
        for (int i = 0; i < 16; i++)
        begin
            result[127 - 8 * i -: 8] = s[i];
        end
        return result;
    endfunction

    // All signals are read as they stood just before each rising edge.
    always @(posedge clk)
    begin
        if (!arstN)
        begin
            reqPrev     = 1'b0;
            ackPrev     = 1'b0;
            edgeCount   = 0;
            haveSameKey = 1'b0;
            testsRun    = 0;
            errorCount  = 0;
        end
        else
        begin
            edgeCount++;
            if (req && !reqPrev)
            begin
                reqEdge = edgeCount;
                kind    = testKind;
                if (testKind == kindKnown)
                begin
                    expected = knownCipher;   // Published value, not the model.
                    if (refEncrypt(reqData.plaintext, reqData.key) != knownCipher)
                    begin
                        $display("reference model does not reproduce the FIPS-197 example");
                        errorCount++;
                    end
                end
                else
                begin
                    expected = refEncrypt(reqData.plaintext, reqData.key);
                end
            end
            if (ack && !ackPrev)
            begin
                testName = $sformatf("%s%0d", kindName(kind), testsRun);
                testsRun++;
                if (dout !== expected)
                begin
                    $display("[FAIL] %s expected %032h actual %032h", testName, expected, dout);
                    errorCount++;
                end
                else
                begin
                    $display("[PASS] %s %032h", testName, dout);
                end
                // ack is seen here one edge after it rose.
                if (edgeCount - reqEdge - 1 != ackLatency)
                begin
                    $display("[FAIL] %s latency expected %0d actual %0d", testName,
                             ackLatency, edgeCount - reqEdge - 1);
                    errorCount++;
                end
                if (kind == kindSameKey)
                begin
                    if (haveSameKey && dout !== sameKeyResult)
                    begin
                        $display("[FAIL] %s repeat expected %032h actual %032h", testName,
                                 sameKeyResult, dout);
                        errorCount++;
                    end
                    sameKeyResult = expected;
                    haveSameKey   = 1'b1;
                end
            end
            if (ack && ackPrev && dout !== expected)
            begin
                $display("[FAIL] %s held expected %032h actual %032h", testName,
                         expected, dout);
                errorCount++;
            end
            if (ackPrev && reqPrev && !ack)
            begin
                $display("%s: ack dropped while req was still high", testName);
                errorCount++;
            end
            if (ackPrev && !reqPrev && ack)
            begin
                $display("%s: ack stayed high after req was seen low", testName);
                errorCount++;
            end
            reqPrev = req;
            ackPrev = ack;
        end
    end

endmodule

`default_nettype wire

//--- dv/aesCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module aesCoreTb;

    localparam logic [1:0] kindKnown     = 2'd0;
    localparam logic [1:0] kindRandom    = 2'd1;
    localparam logic [1:0] kindSameKey   = 2'd2;
    localparam int         numRandom     = 16;
    localparam int         numTests      = numRandom + 3;
    localparam int         timeoutCycles = 20 * 30 + 20;   // Room for reset.

    logic              clk;
    logic              arstN;
    logic              req;
    aesPkg::aesReq_t   reqData;
    logic              ack;
    aesPkg::aesState_u dout;
    logic [1:0]        testKind;
    int                testsRun;
    int                errorCount;
    int                cycleCount = 0;

    aesCore u_aesCore
    (
        .clk     (clk),
        .arstN   (arstN),
        .req     (req),
        .reqData (reqData),
        .ack     (ack),
        .dout    (dout)
    );

    aesChecker u_aesChecker
    (
        .clk        (clk),
        .arstN      (arstN),
        .req        (req),
        .reqData    (reqData),
        .ack        (ack),
        .dout       (dout),
        .testKind   (testKind),
        .testsRun   (testsRun),
        .errorCount (errorCount)
    );

    bind aesRoundControl aesCoreAsserts u_aesCoreAsserts
    (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .ack   (ack),
        .state (state)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Starts and ends on a falling edge, so calls run back to back.
    task automatic runBlock(input logic [127:0] plaintext, input logic [127:0] key,
                            input logic [1:0] kind, input int hold);
        req      = 1'b1;
        reqData  = {plaintext, key};
        testKind = kind;
        do @(negedge clk); while (!ack);
        repeat (hold) @(negedge clk);   // Back-pressure.
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    initial
    begin
        logic [127:0] pt;
        logic [127:0] key;
        int           hold;
        void'($urandom(32'he0e4_2e3f));
        arstN    = 1'b0;
        req      = 1'b0;
        reqData  = '0;
        testKind = kindKnown;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        runBlock(128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff,
                 128'h0001_0203_0405_0607_0809_0a0b_0c0d_0e0f, kindKnown, 0);
        repeat (numRandom)
        begin
            pt   = {$urandom, $urandom, $urandom, $urandom};
            key  = {$urandom, $urandom, $urandom, $urandom};
            hold = $urandom % 9;
            runBlock(pt, key, kindRandom, hold);
        end
        pt  = {$urandom, $urandom, $urandom, $urandom};
        key = {$urandom, $urandom, $urandom, $urandom};
        runBlock(pt, key, kindSameKey, 2);
        runBlock(pt, key, kindSameKey, 0);
        @(negedge clk);
        $display("%0d of %0d tests run, %0d errors", testsRun, numTests, errorCount);
        if (errorCount == 0 && testsRun == numTests)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= timeoutCycles)
        begin
            $display("run stopped after %0d cycles without finishing its tests", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
logic/aesPkg.sv
logic/aesKeySchedule.sv
logic/aesRoundDatapath.sv
logic/aesRoundControl.sv
logic/aesCore.sv
dv/aesCoreAsserts.sv
dv/aesChecker.sv
dv/aesCoreTb.sv

//--- Makefile
TOP = aesCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
